// File: logic/bmc_pwrseq_pkg.sv
// shared rail indices, rail vector type and sequencer states; import into any design unit using them
package bmc_pwrseq_pkg;

   //////////////////////////////////////////////////
   // rail indexing
   //////////////////////////////////////////////////
   localparam int NUM_RAILS = 4;                  // aux regulators under control

   localparam int RAIL_P2V5 = 0;                  // first up, last down
   localparam int RAIL_P1V0 = 1;
   localparam int RAIL_P1V2 = 2;
   localparam int RAIL_P1V8 = 3;                  // also enables the PCH aux rail

   typedef logic [NUM_RAILS-1:0] rail_vec_t;      // one bit per regulator

   //////////////////////////////////////////////////
   // sequencer states
   //////////////////////////////////////////////////
   typedef enum logic [3:0] {
      INIT,                                       // rails off, waiting for enable
      P2V5_ON,
      P1V0_ON,
      P1V2_ON,
      P1V8_ON,                                    // no settle time on this step
      PWR_OK,                                     // all rails up
      P1V8_OFF,                                   // power-down entry point
      P1V2_OFF,
      P1V0_OFF,
      P2V5_OFF
   } seq_state_t;

endpackage : bmc_pwrseq_pkg

// File: logic/pwr_seq_if.sv
// internal bundle between sequencer, fault monitor and reset generator; instantiate once in the top
interface pwr_seq_if
   import bmc_pwrseq_pkg::*;
();

   rail_vec_t rail_en;                            // registered regulator enables
   logic      pwr_ok;                             // all rails up
   rail_vec_t rail_fault;                         // sticky per-rail faults
   logic      pwr_fault;                          // sticky combined fault

   // sequencer side
   modport seq (
      output rail_en,
      output pwr_ok,
      input  pwr_fault
   );

   // fault monitor side
   modport mon (
      input  rail_en,
      output rail_fault,
      output pwr_fault
   );

   // reset generator only needs power-ok
   modport srst (
      input  pwr_ok
   );

endinterface : pwr_seq_if

// File: logic/settle_timer.sv
// generic delay counter; hold restart high to reload, elapsed flags CYCLES clocks after restart drops
module settle_timer
#(
   parameter int CYCLES = 2000                    // clocks to count after restart
)
(
   input  logic iClk,
   input  logic iRst_n,
   input  logic restart,                          // synchronous reload request
   output logic elapsed                           // count reached, held until restart
);

   //////////////////////////////////////////////////
   // counter
   //////////////////////////////////////////////////
   localparam int CW = $clog2(CYCLES + 1);        // wide enough to hold CYCLES itself

   logic [CW-1:0] cnt;                            // clocks since restart dropped

   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         cnt <= '0;
      end
      else if (restart)
      begin
         cnt <= '0;                               // reload while requested
      end
      else if (cnt != CW'(CYCLES))
      begin
         cnt <= cnt + 1'b1;                       // count up, stop at terminal value
      end
   end

   // terminal count decode, stays true until the next reload
   assign elapsed = (cnt == CW'(CYCLES));

endmodule : settle_timer

// File: logic/bmc_pwrseq_fsm.sv
// aux rail power-up / power-down sequencer; drives enables and power-ok through the seq modport
module bmc_pwrseq_fsm
   import bmc_pwrseq_pkg::*;
#(
   parameter int STEP_DLY = 2000                  // settle clocks per sequence step
)
(
   input  logic      iClk,
   input  logic      iRst_n,
   input  logic      bmc_pwr_en,                  // high requests power-up
   input  rail_vec_t pwrgd,                       // regulator power-goods
   pwr_seq_if.seq    seq
);

   seq_state_t state;                             // current step
   seq_state_t prev_state;                        // state one clock ago
   seq_state_t next_state;
   rail_vec_t  rail_en_q;                         // enable registers
   logic       pwr_ok_q;
   logic       step_restart;                      // state just changed
   logic       step_elapsed;
   logic       step_done;                         // settle time met in current state
   logic       pwr_down_req;                      // abort power-up or leave PWR_OK

   //////////////////////////////////////////////////
   // step settle timer
   //////////////////////////////////////////////////
   assign step_restart = (state != prev_state);   // reload on every transition
   assign step_done    = step_elapsed && !step_restart; // ignore stale elapsed on entry
   assign pwr_down_req = !bmc_pwr_en || seq.pwr_fault;

   settle_timer #(
      .CYCLES (STEP_DLY)
   ) u_step_timer (
      .iClk    (iClk),
      .iRst_n  (iRst_n),
      .restart (step_restart),
      .elapsed (step_elapsed)
   );

   //////////////////////////////////////////////////
   // next state
   //////////////////////////////////////////////////
   always_comb
   begin
      next_state = state;                         // hold by default
      case (state)
         INIT:
            if (bmc_pwr_en && !seq.pwr_fault) next_state = P2V5_ON; // faults block restart
         P2V5_ON:
            if (pwr_down_req)                               next_state = P1V8_OFF;
            else if (pwrgd[RAIL_P2V5] && step_done)         next_state = P1V0_ON;
         P1V0_ON:
            if (pwr_down_req)                               next_state = P1V8_OFF;
            else if (pwrgd[RAIL_P1V0] && step_done)         next_state = P1V2_ON;
         P1V2_ON:
            if (pwr_down_req)                               next_state = P1V8_OFF;
            else if (pwrgd[RAIL_P1V2] && step_done)         next_state = P1V8_ON;
         P1V8_ON:
            if (pwr_down_req)                               next_state = P1V8_OFF;
            else if (pwrgd[RAIL_P1V8])                      next_state = PWR_OK; // no settle
         PWR_OK:
            if (pwr_down_req)                               next_state = P1V8_OFF;
         // power-down walks the rails in reverse, each waits for its pwrgd to clear
         P1V8_OFF:
            if (!pwrgd[RAIL_P1V8] && step_done)             next_state = P1V2_OFF;
         P1V2_OFF:
            if (!pwrgd[RAIL_P1V2] && step_done)             next_state = P1V0_OFF;
         P1V0_OFF:
            if (!pwrgd[RAIL_P1V0] && step_done)             next_state = P2V5_OFF;
         P2V5_OFF:
            if (!pwrgd[RAIL_P2V5] && step_done)             next_state = INIT;
         default:
            next_state = INIT;                    // recover from illegal encodings
      endcase
   end

   //////////////////////////////////////////////////
   // state and output registers
   //////////////////////////////////////////////////
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         state      <= INIT;
         prev_state <= INIT;
         rail_en_q  <= '0;                        // all regulators off
         pwr_ok_q   <= 1'b0;
      end
      else
      begin
         state      <= next_state;
         prev_state <= state;                     // one clock behind for restart detect
         pwr_ok_q   <= (state == PWR_OK);         // follows PWR_OK one clock late
         case (state)
            INIT     : rail_en_q <= '0;
            P2V5_ON  : rail_en_q[RAIL_P2V5] <= 1'b1;
            P1V0_ON  : rail_en_q[RAIL_P1V0] <= 1'b1;
            P1V2_ON  : rail_en_q[RAIL_P1V2] <= 1'b1;
            P1V8_ON  : rail_en_q[RAIL_P1V8] <= 1'b1;
            P1V8_OFF : rail_en_q[RAIL_P1V8] <= 1'b0;
            P1V2_OFF : rail_en_q[RAIL_P1V2] <= 1'b0;
            P1V0_OFF : rail_en_q[RAIL_P1V0] <= 1'b0;
            P2V5_OFF : rail_en_q[RAIL_P2V5] <= 1'b0;
            default  : rail_en_q <= rail_en_q;    // PWR_OK keeps everything on
         endcase
      end
   end

   assign seq.rail_en = rail_en_q;
   assign seq.pwr_ok  = pwr_ok_q;

endmodule : bmc_pwrseq_fsm

// File: logic/rail_fault_monitor.sv
// watches power-goods of enabled rails and latches drop-outs as sticky faults until reset
module rail_fault_monitor
   import bmc_pwrseq_pkg::*;
(
   input  logic      iClk,
   input  logic      iRst_n,
   input  rail_vec_t pwrgd,                       // regulator power-goods
   pwr_seq_if.mon    mon
);

   rail_vec_t pwrgd_q;                            // power-good one clock ago
   rail_vec_t drop;                               // falling pwrgd on an enabled rail
   rail_vec_t fail_q;                             // internal sticky fail flags
   rail_vec_t rail_fault_q;                       // fault outputs, one clock behind fail
   logic      pwr_fault_q;

   //////////////////////////////////////////////////
   // drop-out detect
   //////////////////////////////////////////////////
   // a rail that was good and goes low while still enabled has failed
   assign drop = mon.rail_en & pwrgd_q & ~pwrgd;

   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         pwrgd_q      <= '0;
         fail_q       <= '0;
         rail_fault_q <= '0;
         pwr_fault_q  <= 1'b0;
      end
      else
      begin
         pwrgd_q      <= pwrgd;                   // edge detect history
         fail_q       <= fail_q | drop;           // set only, cleared by reset
         rail_fault_q <= fail_q;                  // second stage to the outputs
         pwr_fault_q  <= pwr_fault_q | (|fail_q); // any rail failure, sticky
      end
   end

   //////////////////////////////////////////////////
   // outputs
   //////////////////////////////////////////////////
   assign mon.rail_fault = rail_fault_q;
   assign mon.pwr_fault  = pwr_fault_q;          // also blocks fsm restart

endmodule : rail_fault_monitor

// File: logic/bmc_srst_gen.sv
// BMC system reset release; holds reset low until power-ok has been stable for SRST_DLY clocks
module bmc_srst_gen
#(
   parameter int SRST_DLY = 4000                  // clocks from power-ok to reset release
)
(
   input  logic     iClk,
   input  logic     iRst_n,
   pwr_seq_if.srst  seq_st,
   output logic     rst_srst_bmc_n                // active low system reset to the BMC
);

   logic dly_elapsed;                             // power-ok held long enough

   // timer held in reload while power is not ok
   settle_timer #(
      .CYCLES (SRST_DLY)
   ) u_srst_timer (
      .iClk    (iClk),
      .iRst_n  (iRst_n),
      .restart (!seq_st.pwr_ok),
      .elapsed (dly_elapsed)
   );

   //////////////////////////////////////////////////
   // reset output
   //////////////////////////////////////////////////
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         rst_srst_bmc_n <= 1'b0;                  // BMC held in reset
      end
      else
      begin
         rst_srst_bmc_n <= seq_st.pwr_ok && dly_elapsed; // drops right after power-ok falls
      end
   end

endmodule : bmc_srst_gen

// File: logic/bmc_pwrseq_top.sv
// top of the BMC aux power sequencer; board-level ports, instantiate with STEP_DLY and SRST_DLY
module bmc_pwrseq_top
   import bmc_pwrseq_pkg::*;
#(
   parameter int STEP_DLY = 2000,                 // settle clocks per sequence step
   parameter int SRST_DLY = 4000                  // power-ok to reset release clocks
)
(
   input  logic iClk,
   input  logic iRst_n,
   input  logic pwrgd_p2v5,                       // regulator power-goods
   input  logic pwrgd_p1v0,
   input  logic pwrgd_p1v2,
   input  logic pwrgd_p1v8,
   input  logic bmc_pwr_en,                       // high to power the rails up
   output logic p2v5_en,                          // regulator enables
   output logic p1v0_en,
   output logic p1v2_en,
   output logic pch_p1v8_en,                      // shared with the PCH
   output logic p2v5_fault,                       // sticky per-rail faults
   output logic p1v0_fault,
   output logic p1v2_fault,
   output logic p1v8_fault,
   output logic bmc_pwr_fault,                    // any rail failed
   output logic bmc_pwr_ok,                       // all rails up
   output logic rst_srst_bmc_n                    // BMC system reset, active low
);

   rail_vec_t pwrgd;                              // packed power-goods

   pwr_seq_if seq_bus ();

   //////////////////////////////////////////////////
   // pack inputs
   //////////////////////////////////////////////////
   assign pwrgd[RAIL_P2V5] = pwrgd_p2v5;
   assign pwrgd[RAIL_P1V0] = pwrgd_p1v0;
   assign pwrgd[RAIL_P1V2] = pwrgd_p1v2;
   assign pwrgd[RAIL_P1V8] = pwrgd_p1v8;

   //////////////////////////////////////////////////
   // sub-modules
   //////////////////////////////////////////////////
   bmc_pwrseq_fsm #(
      .STEP_DLY (STEP_DLY)
   ) u_fsm (
      .iClk       (iClk),
      .iRst_n     (iRst_n),
      .bmc_pwr_en (bmc_pwr_en),
      .pwrgd      (pwrgd),
      .seq        (seq_bus.seq)
   );

   rail_fault_monitor u_fault_mon (
      .iClk   (iClk),
      .iRst_n (iRst_n),
      .pwrgd  (pwrgd),
      .mon    (seq_bus.mon)
   );

   bmc_srst_gen #(
      .SRST_DLY (SRST_DLY)
   ) u_srst_gen (
      .iClk           (iClk),
      .iRst_n         (iRst_n),
      .seq_st         (seq_bus.srst),
      .rst_srst_bmc_n (rst_srst_bmc_n)
   );

   //////////////////////////////////////////////////
   // unpack outputs
   //////////////////////////////////////////////////
   assign p2v5_en       = seq_bus.rail_en[RAIL_P2V5];
   assign p1v0_en       = seq_bus.rail_en[RAIL_P1V0];
   assign p1v2_en       = seq_bus.rail_en[RAIL_P1V2];
   assign pch_p1v8_en   = seq_bus.rail_en[RAIL_P1V8];
   assign p2v5_fault    = seq_bus.rail_fault[RAIL_P2V5];
   assign p1v0_fault    = seq_bus.rail_fault[RAIL_P1V0];
   assign p1v2_fault    = seq_bus.rail_fault[RAIL_P1V2];
   assign p1v8_fault    = seq_bus.rail_fault[RAIL_P1V8];
   assign bmc_pwr_fault = seq_bus.pwr_fault;
   assign bmc_pwr_ok    = seq_bus.pwr_ok;

endmodule : bmc_pwrseq_top

// File: tb/bmc_pwrseq_checker.sv
// concurrent assertions on enable ordering, reset release and sticky fault; bound into the top
module bmc_pwrseq_checker
#(
   parameter int SRST_DLY = 4000                  // power-ok to reset release clocks
)
(
   input logic iClk,
   input logic iRst_n,
   input logic p2v5_en,
   input logic p1v0_en,
   input logic p1v2_en,
   input logic pch_p1v8_en,
   input logic bmc_pwr_fault,
   input logic bmc_pwr_ok,
   input logic rst_srst_bmc_n
);

   //////////////////////////////////////////////////
   // rail ordering
   //////////////////////////////////////////////////
   // a later rail is never on without the one before it
   p1v0_needs_p2v5 : assert property (@(posedge iClk) disable iff (!iRst_n)
      p1v0_en |-> p2v5_en)
      else $error("p1v0_en high while p2v5_en low");

   p1v2_needs_p1v0 : assert property (@(posedge iClk) disable iff (!iRst_n)
      p1v2_en |-> p1v0_en)
      else $error("p1v2_en high while p1v0_en low");

   p1v8_needs_p1v2 : assert property (@(posedge iClk) disable iff (!iRst_n)
      pch_p1v8_en |-> p1v2_en)
      else $error("pch_p1v8_en high while p1v2_en low");

   //////////////////////////////////////////////////
   // reset release and fault
   //////////////////////////////////////////////////
   // released srst means power-ok was already up a full reset delay earlier
   srst_needs_pwr_ok : assert property (@(posedge iClk) disable iff (!iRst_n)
      rst_srst_bmc_n |-> $past(bmc_pwr_ok, SRST_DLY))
      else $error("rst_srst_bmc_n released without bmc_pwr_ok held for the reset delay");

   fault_is_sticky : assert property (@(posedge iClk) disable iff (!iRst_n)
      !$fell(bmc_pwr_fault))
      else $error("bmc_pwr_fault cleared while out of reset");

endmodule : bmc_pwrseq_checker

bind bmc_pwrseq_top bmc_pwrseq_checker #(.SRST_DLY (SRST_DLY)) u_checker (.*);

// File: tb/tb_bmc_pwrseq.sv
// testbench for the BMC aux power sequencer; runs a scenario table against a regulator model
module tb_bmc_pwrseq;

   localparam int STEP_DLY = 8;
   localparam int SRST_DLY = 16;
   localparam int NROWS    = 7;
   localparam int LIMIT    = 300;                 // max clocks for any single wait
   localparam int K_NORMAL = 0;                   // full up and down cycle
   localparam int K_EN_DROP = 1;                  // enable dropped during power-up
   localparam int K_DROPOUT = 2;                  // power-good pulled on an enabled rail

   // scenario table: kind, rail or step, expected fault vector
   int         kind_tbl [NROWS] = '{K_NORMAL, K_EN_DROP, K_DROPOUT, K_DROPOUT,
                                    K_NORMAL, K_EN_DROP, K_DROPOUT};
   int         arg_tbl  [NROWS] = '{0, 1, 2, 0, 0, 2, 3};
   logic [3:0] fault_tbl[NROWS] = '{4'b0000, 4'b0000, 4'b0100, 4'b0001,
                                    4'b0000, 4'b0000, 4'b1000};

   logic iClk = 1'b0;
   logic iRst_n;
   logic bmc_pwr_en;
   logic [3:0] pg = '0;                           // model power-goods, p2v5 in bit 0
   logic [3:0] kill;                              // forced drop-out per rail
   logic p2v5_en, p1v0_en, p1v2_en, pch_p1v8_en;
   logic p2v5_fault, p1v0_fault, p1v2_fault, p1v8_fault;
   logic bmc_pwr_fault, bmc_pwr_ok, rst_srst_bmc_n;
   logic [3:0] en_vec;
   logic [3:0] fault_vec;
   int errors = 0;
   int fails  = 0;
   int dly [4];                                   // regulator delay counters
   int cyc = 0;
   int rise_cyc [4];
   int fall_cyc [4];
   int ok_rise = 0;
   int srst_rise = 0;
   int rise_cnt = 0;
   logic [3:0] en_prev = '0;
   logic ok_prev = 1'b0;
   logic srst_prev = 1'b0;

   assign en_vec    = {pch_p1v8_en, p1v2_en, p1v0_en, p2v5_en};
   assign fault_vec = {p1v8_fault, p1v2_fault, p1v0_fault, p2v5_fault};

   always #20 iClk = ~iClk;

   bmc_pwrseq_top #(
      .STEP_DLY (STEP_DLY),
      .SRST_DLY (SRST_DLY)
   ) UUT (
      .iClk           (iClk),
      .iRst_n         (iRst_n),
      .pwrgd_p2v5     (pg[0]),
      .pwrgd_p1v0     (pg[1]),
      .pwrgd_p1v2     (pg[2]),
      .pwrgd_p1v8     (pg[3]),
      .bmc_pwr_en     (bmc_pwr_en),
      .p2v5_en        (p2v5_en),
      .p1v0_en        (p1v0_en),
      .p1v2_en        (p1v2_en),
      .pch_p1v8_en    (pch_p1v8_en),
      .p2v5_fault     (p2v5_fault),
      .p1v0_fault     (p1v0_fault),
      .p1v2_fault     (p1v2_fault),
      .p1v8_fault     (p1v8_fault),
      .bmc_pwr_fault  (bmc_pwr_fault),
      .bmc_pwr_ok     (bmc_pwr_ok),
      .rst_srst_bmc_n (rst_srst_bmc_n)
   );

   //////////////////////////////////////////////////
   // regulator model
   //////////////////////////////////////////////////
   always @(posedge iClk)
   begin : regulators
      logic tgt;
      for (int i = 0; i < 4; i++)
      begin
         tgt = en_vec[i] && !kill[i];            // level the rail is heading to
         if (kill[i])
         begin
            pg[i]  <= 1'b0;                       // hard drop-out, no delay
            dly[i] <= 0;
         end
         else if (pg[i] == tgt)
            dly[i] <= 0;
         else if (dly[i] == 0)
            dly[i] <= int'($urandom_range(5, 1)); // ramp time in clocks
         else if (dly[i] == 1)
         begin
            pg[i]  <= tgt;
            dly[i] <= 0;
         end
         else
            dly[i] <= dly[i] - 1;
      end
   end

   //////////////////////////////////////////////////
   // edge recorder, samples on the falling edge
   //////////////////////////////////////////////////
   always @(negedge iClk)
   begin
      for (int i = 0; i < 4; i++)
      begin
         if (en_vec[i] && !en_prev[i])
         begin
            rise_cyc[i] = cyc;
            rise_cnt    = rise_cnt + 1;
         end
         if (!en_vec[i] && en_prev[i])
            fall_cyc[i] = cyc;
      end
      if (bmc_pwr_ok && !ok_prev)
         ok_rise = cyc;
      if (rst_srst_bmc_n && !srst_prev)
         srst_rise = cyc;
      en_prev   = en_vec;
      ok_prev   = bmc_pwr_ok;
      srst_prev = rst_srst_bmc_n;
      cyc       = cyc + 1;
   end

   task automatic check(input string name, input int got, input int exp);
      if (got != exp)
      begin
         $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
         errors = errors + 1;
      end
   endtask

   function automatic logic out_bit(input int sel);
      if (sel < 4)
         return en_vec[sel];
      else if (sel == 4)
         return bmc_pwr_ok;
      else
         return rst_srst_bmc_n;
   endfunction

   // sel 0..3 enables, 4 power-ok, 5 system reset
   task automatic wait_level(input int sel, input logic val, input string what);
      int n;
      n = 0;
      @(negedge iClk);
      while (out_bit(sel) != val && n < LIMIT)
      begin
         @(negedge iClk);
         n = n + 1;
      end
      if (out_bit(sel) != val)
      begin
         $display("%s did not reach %0d within %0d clocks", what, val, LIMIT);
         errors = errors + 1;
      end
   endtask

   task automatic check_fall_order();
      check("p1v8 falls before p1v2", int'(fall_cyc[3] < fall_cyc[2]), 1);
      check("p1v2 falls before p1v0", int'(fall_cyc[2] < fall_cyc[1]), 1);
      check("p1v0 falls before p2v5", int'(fall_cyc[1] < fall_cyc[0]), 1);
   endtask

   //////////////////////////////////////////////////
   // scenario runner
   //////////////////////////////////////////////////
   task automatic run_row(input int row);
      int err0;
      int row_start;
      int snap;
      err0 = errors;
      @(posedge iClk);
      iRst_n     <= 1'b0;
      bmc_pwr_en <= 1'b0;
      kill       <= '0;
      repeat (7) @(posedge iClk);
      @(negedge iClk);
      check("enables in reset", int'(en_vec), 0);
      check("bmc_pwr_ok in reset", int'(bmc_pwr_ok), 0);
      check("rst_srst_bmc_n in reset", int'(rst_srst_bmc_n), 0);
      check("faults in reset", int'({fault_vec, bmc_pwr_fault}), 0);
      @(posedge iClk);
      iRst_n     <= 1'b1;
      bmc_pwr_en <= 1'b1;
      row_start = cyc;
      case (kind_tbl[row])
         K_NORMAL:
         begin
            wait_level(5, 1'b1, "rst_srst_bmc_n");
            @(posedge iClk);
            check("p2v5 to p1v0 gap", int'(rise_cyc[1] - rise_cyc[0] >= STEP_DLY), 1);
            check("p1v0 to p1v2 gap", int'(rise_cyc[2] - rise_cyc[1] >= STEP_DLY), 1);
            check("p1v8 after p1v2", int'(rise_cyc[3] > rise_cyc[2]), 1);
            check("pwr_ok after p1v8", int'(ok_rise > rise_cyc[3]), 1);
            check("srst release delay", int'(srst_rise - ok_rise >= SRST_DLY), 1);
            bmc_pwr_en <= 1'b0;
            wait_level(5, 1'b0, "rst_srst_bmc_n");
            check("bmc_pwr_ok after enable drop", int'(bmc_pwr_ok), 0);
            wait_level(0, 1'b0, "p2v5_en");
            @(posedge iClk);
            check_fall_order();
            check("fault vector", int'(fault_vec), int'(fault_tbl[row]));
            check("bmc_pwr_fault", int'(bmc_pwr_fault), 0);
         end
         K_EN_DROP:
         begin
            wait_level(arg_tbl[row], 1'b1, "enable at drop step");
            @(posedge iClk);
            bmc_pwr_en <= 1'b0;
            wait_level(0, 1'b0, "p2v5_en");
            @(posedge iClk);
            check("enables after abort", int'(en_vec), 0);
            check("bmc_pwr_ok never rose", int'(ok_rise < row_start), 1);
            check("fault vector", int'(fault_vec), int'(fault_tbl[row]));
         end
         default:
         begin
            wait_level(4, 1'b1, "bmc_pwr_ok");
            @(posedge iClk);
            kill[arg_tbl[row]] <= 1'b1;
            wait_level(0, 1'b0, "p2v5_en");
            @(posedge iClk);
            check_fall_order();
            check("fault vector", int'(fault_vec), int'(fault_tbl[row]));
            check("bmc_pwr_fault", int'(bmc_pwr_fault), 1);
            snap = rise_cnt;
            repeat (4 * STEP_DLY) @(posedge iClk);
            check("no restart after fault", rise_cnt - snap, 0);
            check("enables stay off", int'(en_vec), 0);
         end
      endcase
      if (errors == err0)
         $display("test %0d kind %0d arg %0d: pass", row, kind_tbl[row], arg_tbl[row]);
      else
      begin
         $display("test %0d kind %0d arg %0d: FAIL", row, kind_tbl[row], arg_tbl[row]);
         fails = fails + 1;
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial
   begin
      void'($urandom(32'hbf28));                  // fixed seed for the regulator ramps
      iRst_n     <= 1'b0;
      bmc_pwr_en <= 1'b0;
      kill       <= '0;
      for (int r = 0; r < NROWS; r++)
         run_row(r);
      $display("tests %0d, failed %0d, check errors %0d", NROWS, fails, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // watchdog sized from the table length
   initial
   begin
      #(NROWS * 600 * 40);
      $display("timeout, the scenario table did not finish in time");
      $display("Something failed");
      $finish;
   end

endmodule : tb_bmc_pwrseq

// File: build.f
logic/bmc_pwrseq_pkg.sv
logic/pwr_seq_if.sv
logic/settle_timer.sv
logic/bmc_pwrseq_fsm.sv
logic/rail_fault_monitor.sv
logic/bmc_srst_gen.sv
logic/bmc_pwrseq_top.sv
tb/bmc_pwrseq_checker.sv
tb/tb_bmc_pwrseq.sv

// File: Makefile
# Verilator build and run of the BMC aux power sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_bmc_pwrseq
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
